// File: issue_top.f
logic/core_config_pkg.sv
logic/core_types_pkg.sv
logic/inst_buffer.sv
logic/reg_file.sv
logic/dispatch.sv
logic/exec_stage.sv
logic/issue_top.sv
verification/dispatch_properties.sv
verification/issue_checker.sv
verification/issue_tb.sv

// File: logic/core_config_pkg.sv
`default_nettype none

package core_config_pkg;

    // Datapath width
    localparam int XLEN = 32;

    // General register file
    localparam int GPR_NUM    = 16;
    localparam int REG_ADDR_W = 4;

    // Two issue slots, each reading two sources
    localparam int ISSUE_WIDTH = 2;
    localparam int RF_RPORTS   = 2 * ISSUE_WIDTH;

    // Instruction buffer, depth must be a power of two
    localparam int IB_DEPTH = 8;
    localparam int IB_PTR_W = $clog2(IB_DEPTH);

    // Immediate field before sign extension
    localparam int IMM_W = 16;

endpackage

`default_nettype wire

// File: logic/core_types_pkg.sv
`default_nettype none

package core_types_pkg;

    import core_config_pkg::*;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_MUL
    } op_e;

    // Output of the decoder, one instruction
    typedef struct packed {
        op_e                   op;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic                  rs1_valid;
        logic                  rs2_valid;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rd_valid;
        logic                  use_imm;
        logic [IMM_W-1:0]      imm;
    } decoded_instr_t;

    // One head entry of the instruction buffer
    typedef struct packed {
        logic           valid;
        decoded_instr_t instr;
    } ib_slot_t;

    // Issue register, dispatch to EX
    typedef struct packed {
        logic                  valid;
        op_e                   op;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rd_valid;
        logic [XLEN-1:0]       operand1;
        logic [XLEN-1:0]       operand2;
    } dispatch_ex_t;

    // Write in flight, seen by dispatch
    typedef struct packed {
        logic                  wreg;
        logic                  data_valid;
        logic [REG_ADDR_W-1:0] wreg_addr;
        logic [XLEN-1:0]       wreg_data;
    } data_forward_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } wb_result_t;

endpackage

`default_nettype wire

// File: logic/dispatch.sv
`timescale 1ns/10ps
`default_nettype none

module dispatch (
    input  logic                                                    clk,
    input  logic                                                    rst_n,
    input  core_types_pkg::ib_slot_t [core_config_pkg::ISSUE_WIDTH-1:0] head_i,
    output logic [core_config_pkg::ISSUE_WIDTH-1:0]                 accept_o,
    output logic [core_config_pkg::RF_RPORTS-1:0][core_config_pkg::REG_ADDR_W-1:0] rf_addr_o,
    input  logic [core_config_pkg::RF_RPORTS-1:0][core_config_pkg::XLEN-1:0] rf_data_i,
    input  core_types_pkg::data_forward_t [core_config_pkg::ISSUE_WIDTH-1:0] fwd_ex_i,
    input  core_types_pkg::data_forward_t [core_config_pkg::ISSUE_WIDTH-1:0] fwd_wb_i,
    output core_types_pkg::dispatch_ex_t [core_config_pkg::ISSUE_WIDTH-1:0] ex_o
);

    import core_config_pkg::*;
    import core_types_pkg::*;

    logic [GPR_NUM-1:0]                busy_q;
    logic [GPR_NUM-1:0]                busy_next;
    logic [GPR_NUM-1:0]                fwd_ready;
    logic [GPR_NUM-1:0]                src_busy;
    logic [RF_RPORTS-1:0][XLEN-1:0]    opnd;
    logic [ISSUE_WIDTH-1:0]            issue;
    logic                              pair_dep;
    logic                              has_mul;
    logic                              mul_in_ex;
    decoded_instr_t                    s0;
    decoded_instr_t                    s1;

    function automatic logic regs_free(input decoded_instr_t ins,
                                       input logic [GPR_NUM-1:0] src_busy_v,
                                       input logic [GPR_NUM-1:0] dst_busy_v);
        logic src_ok;
        logic dst_ok;
        src_ok = !(ins.rs1_valid && src_busy_v[ins.rs1]) &&
                 !(ins.rs2_valid && src_busy_v[ins.rs2]);
        dst_ok = !(ins.rd_valid && dst_busy_v[ins.rd]);
        return src_ok && dst_ok;
    endfunction

    assign s0 = head_i[0].instr;
    assign s1 = head_i[1].instr;

    // Registers whose value is on a forward path this cycle
    always_comb begin
        fwd_ready = '0;
        for (int p = 0; p < ISSUE_WIDTH; p++) begin
            if (fwd_ex_i[p].data_valid) fwd_ready[fwd_ex_i[p].wreg_addr] = 1'b1;
            if (fwd_wb_i[p].data_valid) fwd_ready[fwd_wb_i[p].wreg_addr] = 1'b1;
        end
    end

    // Sources may take a forwarded value, destinations wait for the clear
    assign src_busy = busy_q & ~fwd_ready;

    // Pair rules
    assign pair_dep = s0.rd_valid && ((s1.rs1_valid && s1.rs1 == s0.rd) ||
                                      (s1.rs2_valid && s1.rs2 == s0.rd) ||
                                      (s1.rd_valid  && s1.rd  == s0.rd));
    assign has_mul = (s0.op == OP_MUL) || (s1.op == OP_MUL);
    // A MUL in EX takes WB port 1 two cycles from now
    assign mul_in_ex = ex_o[0].valid && ex_o[0].op == OP_MUL;

    assign issue[0] = head_i[0].valid && regs_free(s0, src_busy, busy_q);
    assign issue[1] = issue[0] && head_i[1].valid && !has_mul && !mul_in_ex &&
                      !pair_dep && regs_free(s1, src_busy, busy_q);
    assign accept_o = issue;

    // Operand select, EX over WB over register file
    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            rf_addr_o[2*i]   = head_i[i].instr.rs1;
            rf_addr_o[2*i+1] = head_i[i].instr.rs2;
        end
        for (int k = 0; k < RF_RPORTS; k++) begin
            opnd[k] = rf_data_i[k];
            for (int p = 0; p < ISSUE_WIDTH; p++) begin
                if (fwd_wb_i[p].wreg && fwd_wb_i[p].wreg_addr == rf_addr_o[k])
                    opnd[k] = fwd_wb_i[p].wreg_data;
            end
            for (int p = 0; p < ISSUE_WIDTH; p++) begin
                if (fwd_ex_i[p].wreg && fwd_ex_i[p].wreg_addr == rf_addr_o[k])
                    opnd[k] = fwd_ex_i[p].wreg_data;
            end
            if (rf_addr_o[k] == '0) opnd[k] = '0;
        end
    end

    // Scoreboard, a new issue wins over a clear of the same register
    always_comb begin
        busy_next = busy_q & ~fwd_ready;
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            if (issue[i] && head_i[i].instr.rd_valid && head_i[i].instr.rd != '0)
                busy_next[head_i[i].instr.rd] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) busy_q <= '0;
        else        busy_q <= busy_next;
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            ex_o[i].op       <= head_i[i].instr.op;
            ex_o[i].rd       <= head_i[i].instr.rd;
            ex_o[i].rd_valid <= head_i[i].instr.rd_valid;
            ex_o[i].operand1 <= opnd[2*i];
            if (head_i[i].instr.use_imm)
                ex_o[i].operand2 <= {{(XLEN-IMM_W){head_i[i].instr.imm[IMM_W-1]}},
                                     head_i[i].instr.imm};
            else
                ex_o[i].operand2 <= opnd[2*i+1];
            if (!rst_n) ex_o[i].valid <= 1'b0;
            else        ex_o[i].valid <= issue[i];
        end
    end

endmodule

`default_nettype wire

// File: logic/exec_stage.sv
`timescale 1ns/10ps
`default_nettype none

module exec_stage (
    input  logic                                                    clk,
    input  logic                                                    rst_n,
    input  core_types_pkg::dispatch_ex_t [core_config_pkg::ISSUE_WIDTH-1:0] ex_i,
    output core_types_pkg::data_forward_t [core_config_pkg::ISSUE_WIDTH-1:0] fwd_ex_o,
    output core_types_pkg::data_forward_t [core_config_pkg::ISSUE_WIDTH-1:0] fwd_wb_o,
    output core_types_pkg::wb_result_t [core_config_pkg::ISSUE_WIDTH-1:0] wb_o
);

    import core_config_pkg::*;
    import core_types_pkg::*;

    logic [ISSUE_WIDTH-1:0][XLEN-1:0] alu_res;
    logic [ISSUE_WIDTH-1:0]           alu_wr;
    logic                             mul_valid_q;
    logic [REG_ADDR_W-1:0]            mul_rd_q;
    logic [XLEN-1:0]                  mul_a_q;
    logic [XLEN-1:0]                  mul_b_q;
    logic [XLEN-1:0]                  mul_prod;

    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            case (ex_i[i].op)
                OP_ADD:  alu_res[i] = ex_i[i].operand1 + ex_i[i].operand2;
                OP_SUB:  alu_res[i] = ex_i[i].operand1 - ex_i[i].operand2;
                OP_AND:  alu_res[i] = ex_i[i].operand1 & ex_i[i].operand2;
                OP_OR:   alu_res[i] = ex_i[i].operand1 | ex_i[i].operand2;
                OP_XOR:  alu_res[i] = ex_i[i].operand1 ^ ex_i[i].operand2;
                OP_SLL:  alu_res[i] = ex_i[i].operand1 << ex_i[i].operand2[4:0];
                default: alu_res[i] = '0;
            endcase
            alu_wr[i] = ex_i[i].valid && ex_i[i].rd_valid && ex_i[i].op != OP_MUL;
            fwd_ex_o[i].wreg       = ex_i[i].valid && ex_i[i].rd_valid;
            fwd_ex_o[i].data_valid = alu_wr[i];
            fwd_ex_o[i].wreg_addr  = ex_i[i].rd;
            fwd_ex_o[i].wreg_data  = alu_res[i];
            fwd_wb_o[i].wreg       = wb_o[i].valid;
            fwd_wb_o[i].data_valid = wb_o[i].valid;
            fwd_wb_o[i].wreg_addr  = wb_o[i].addr;
            fwd_wb_o[i].wreg_data  = wb_o[i].data;
        end
    end

    // Multiply register, a MUL only ever issues from slot 0
    always_ff @(posedge clk) begin
        mul_rd_q <= ex_i[0].rd;
        mul_a_q  <= ex_i[0].operand1;
        mul_b_q  <= ex_i[0].operand2;
        if (!rst_n) mul_valid_q <= 1'b0;
        else        mul_valid_q <= ex_i[0].valid && ex_i[0].rd_valid && ex_i[0].op == OP_MUL;
    end

    assign mul_prod = mul_a_q * mul_b_q;

    // Writeback register, port 1 is shared by slot 1 and the multiplier
    always_ff @(posedge clk) begin
        wb_o[0].addr <= ex_i[0].rd;
        wb_o[0].data <= alu_res[0];
        if (mul_valid_q) begin
            wb_o[1].addr <= mul_rd_q;
            wb_o[1].data <= mul_prod;
        end else begin
            wb_o[1].addr <= ex_i[1].rd;
            wb_o[1].data <= alu_res[1];
        end
        if (!rst_n) begin
            wb_o[0].valid <= 1'b0;
            wb_o[1].valid <= 1'b0;
        end else begin
            wb_o[0].valid <= alu_wr[0];
            wb_o[1].valid <= alu_wr[1] || mul_valid_q;
        end
    end

endmodule

`default_nettype wire

// File: logic/inst_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module inst_buffer (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic                                                 push_i,
    input  core_types_pkg::decoded_instr_t                       push_instr_i,
    output logic                                                 ready_o,
    input  logic [core_config_pkg::ISSUE_WIDTH-1:0]              pop_i,
    output core_types_pkg::ib_slot_t [core_config_pkg::ISSUE_WIDTH-1:0] head_o
);

    import core_config_pkg::*;
    import core_types_pkg::*;

    decoded_instr_t        mem [IB_DEPTH];
    logic [IB_PTR_W-1:0]   wr_ptr;
    logic [IB_PTR_W-1:0]   rd_ptr;
    logic [IB_PTR_W:0]     count;
    logic [IB_PTR_W:0]     pop_cnt;
    logic                  push_ok;

    assign ready_o = (count != (IB_PTR_W + 1)'(IB_DEPTH));
    assign push_ok = push_i && ready_o;

    // Number of entries taken by dispatch this cycle
    always_comb begin
        pop_cnt = '0;
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            pop_cnt = pop_cnt + (IB_PTR_W + 1)'(pop_i[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_instr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            rd_ptr <= rd_ptr + pop_cnt[IB_PTR_W-1:0];
            count  <= count + (IB_PTR_W + 1)'(push_ok) - pop_cnt;
        end
    end

    // Oldest entries first, pointer wraps on its own
    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            head_o[i].valid = (count > i);
            head_o[i].instr = mem[rd_ptr + IB_PTR_W'(i)];
        end
    end

endmodule

`default_nettype wire

// File: logic/issue_top.sv
`timescale 1ns/10ps
`default_nettype none

module issue_top (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic                                                 in_valid_i,
    input  core_types_pkg::decoded_instr_t                       in_instr_i,
    output logic                                                 in_ready_o,
    output core_types_pkg::wb_result_t [core_config_pkg::ISSUE_WIDTH-1:0] wb_o
);

    import core_config_pkg::*;
    import core_types_pkg::*;

    ib_slot_t [ISSUE_WIDTH-1:0]            head;
    logic [ISSUE_WIDTH-1:0]                accept;
    logic [RF_RPORTS-1:0][REG_ADDR_W-1:0]  rf_addr;
    logic [RF_RPORTS-1:0][XLEN-1:0]        rf_data;
    data_forward_t [ISSUE_WIDTH-1:0]       fwd_ex;
    data_forward_t [ISSUE_WIDTH-1:0]       fwd_wb;
    dispatch_ex_t [ISSUE_WIDTH-1:0]        ex;

    inst_buffer u_inst_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .push_i       (in_valid_i),
        .push_instr_i (in_instr_i),
        .ready_o      (in_ready_o),
        .pop_i        (accept),
        .head_o       (head)
    );

    dispatch u_dispatch (
        .clk       (clk),
        .rst_n     (rst_n),
        .head_i    (head),
        .accept_o  (accept),
        .rf_addr_o (rf_addr),
        .rf_data_i (rf_data),
        .fwd_ex_i  (fwd_ex),
        .fwd_wb_i  (fwd_wb),
        .ex_o      (ex)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .raddr_i (rf_addr),
        .rdata_o (rf_data),
        .wb_i    (wb_o)
    );

    exec_stage u_exec_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .ex_i     (ex),
        .fwd_ex_o (fwd_ex),
        .fwd_wb_o (fwd_wb),
        .wb_o     (wb_o)
    );

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  logic                                                    clk,
    input  logic                                                    rst_n,
    input  logic [core_config_pkg::RF_RPORTS-1:0][core_config_pkg::REG_ADDR_W-1:0] raddr_i,
    output logic [core_config_pkg::RF_RPORTS-1:0][core_config_pkg::XLEN-1:0] rdata_o,
    input  core_types_pkg::wb_result_t [core_config_pkg::ISSUE_WIDTH-1:0] wb_i
);

    import core_config_pkg::*;
    import core_types_pkg::*;

    logic [XLEN-1:0] regs [GPR_NUM];

    // Later port wins on a shared address
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < GPR_NUM; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                if (wb_i[i].valid && wb_i[i].addr != '0) begin
                    regs[wb_i[i].addr] <= wb_i[i].data;
                end
            end
        end
    end

    // r0 is never written so it reads zero
    always_comb begin
        for (int k = 0; k < RF_RPORTS; k++) begin
            rdata_o[k] = regs[raddr_i[k]];
        end
    end

endmodule

`default_nettype wire

// File: verification/dispatch_properties.sv
`timescale 1ns/10ps
`default_nettype none

module dispatch_properties (
    input logic                                                        clk,
    input logic                                                        rst_n,
    input core_types_pkg::ib_slot_t [core_config_pkg::ISSUE_WIDTH-1:0] head_i,
    input logic [core_config_pkg::ISSUE_WIDTH-1:0]                     accept_i,
    input logic [core_config_pkg::GPR_NUM-1:0]                         busy_i,
    input core_types_pkg::data_forward_t [core_config_pkg::ISSUE_WIDTH-1:0] fwd_ex_i,
    input core_types_pkg::data_forward_t [core_config_pkg::ISSUE_WIDTH-1:0] fwd_wb_i,
    input core_types_pkg::dispatch_ex_t [core_config_pkg::ISSUE_WIDTH-1:0]  ex_i
);

    import core_config_pkg::*;
    import core_types_pkg::*;

    int unsigned            fail_count = 0;
    logic [GPR_NUM-1:0]     avail;
    logic [ISSUE_WIDTH-1:0] regs_ok;

    // A source is usable when idle or when its value sits on a forward path
    always_comb begin
        avail = ~busy_i;
        for (int p = 0; p < ISSUE_WIDTH; p++) begin
            if (fwd_ex_i[p].data_valid) avail[fwd_ex_i[p].wreg_addr] = 1'b1;
            if (fwd_wb_i[p].data_valid) avail[fwd_wb_i[p].wreg_addr] = 1'b1;
        end
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            regs_ok[i] = (!head_i[i].instr.rs1_valid || avail[head_i[i].instr.rs1]) &&
                         (!head_i[i].instr.rs2_valid || avail[head_i[i].instr.rs2]) &&
                         (!head_i[i].instr.rd_valid || !busy_i[head_i[i].instr.rd]);
        end
    end

    a_accept_in_order: assert property (
        @(posedge clk) disable iff (!rst_n) accept_i != 2'b10
    ) else begin
        $error("slot 1 accepted while slot 0 was held");
        fail_count++;
    end

    a_slot0_regs_free: assert property (
        @(posedge clk) disable iff (!rst_n) accept_i[0] |-> regs_ok[0]
    ) else begin
        $error("slot 0 accepted with a busy register");
        fail_count++;
    end

    a_slot1_regs_free: assert property (
        @(posedge clk) disable iff (!rst_n) accept_i[1] |-> regs_ok[1]
    ) else begin
        $error("slot 1 accepted with a busy register");
        fail_count++;
    end

    a_idle_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |=> !(ex_i[0].valid || ex_i[1].valid)
    ) else begin
        $error("issue register valid right after reset release");
        fail_count++;
    end

endmodule

bind dispatch dispatch_properties u_dispatch_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .head_i   (head_i),
    .accept_i (accept_o),
    .busy_i   (busy_q),
    .fwd_ex_i (fwd_ex_i),
    .fwd_wb_i (fwd_wb_i),
    .ex_i     (ex_o)
);

`default_nettype wire

// File: verification/issue_checker.sv
`timescale 1ns/10ps
`default_nettype none

module issue_checker (
    input  logic                                                         clk,
    input  logic                                                         rst_n,
    input  core_types_pkg::wb_result_t [core_config_pkg::ISSUE_WIDTH-1:0] wb_i,
    output int unsigned                                                  error_cnt_o,
    output int unsigned                                                  write_cnt_o
);

    import core_config_pkg::*;
    import core_types_pkg::*;

    localparam int MAX_PER_REG = 16;

    // Expected writes per register, oldest at q_head
    logic [XLEN-1:0] exp_val [GPR_NUM][MAX_PER_REG];
    int              exp_row [GPR_NUM][MAX_PER_REG];
    int              q_head  [GPR_NUM] = '{default: 0};
    int              q_tail  [GPR_NUM] = '{default: 0};
    int unsigned     errors = 0;
    int unsigned     writes = 0;

    assign error_cnt_o = errors;
    assign write_cnt_o = writes;

    task automatic add_expected(input int rd, input int row, input logic [XLEN-1:0] value);
        exp_val[rd][q_tail[rd]] = value;
        exp_row[rd][q_tail[rd]] = row;
        q_tail[rd]++;
    endtask

    task automatic check_write(input int rd, input logic [XLEN-1:0] data);
        int idx;
        writes++;
        if (q_head[rd] == q_tail[rd]) begin
            $display("%0t: write of 0x%08h to r%0d arrived with no write to it pending",
                     $time, data, rd);
            errors++;
        end else begin
            idx = q_head[rd];
            q_head[rd]++;
            if (data !== exp_val[rd][idx]) begin
                $display("[ERROR] %0t wb_o data (row %0d, r%0d): expected 0x%08h, got 0x%08h",
                         $time, exp_row[rd][idx], rd, exp_val[rd][idx], data);
                errors++;
            end else begin
                $display("row %0d: r%0d = 0x%08h ok", exp_row[rd][idx], rd, data);
            end
        end
    endtask

    // Writes still pending at the end of the run
    task automatic report_missing(output int missing);
        missing = 0;
        for (int r = 0; r < GPR_NUM; r++) begin
            while (q_head[r] != q_tail[r]) begin
                $display("row %0d: expected write to r%0d never arrived",
                         exp_row[r][q_head[r]], r);
                q_head[r]++;
                missing++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            for (int p = 0; p < ISSUE_WIDTH; p++) begin
                if (wb_i[p].valid) check_write(int'(wb_i[p].addr), wb_i[p].data);
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/issue_tb.sv
`timescale 1ns/10ps
`default_nettype none

module issue_tb;

    import core_config_pkg::*;
    import core_types_pkg::*;

    localparam int NUM_ROWS     = 36;
    localparam int MAX_CYCLES   = NUM_ROWS * 10 + 200;
    localparam int RESET_CYCLES = 16;

    typedef struct packed {
        decoded_instr_t  instr;
        logic [XLEN-1:0] expected;
        logic            burst;
    } row_t;

    logic                         clk;
    logic                         rst_n;
    logic                         in_valid;
    decoded_instr_t               in_instr;
    logic                         in_ready;
    wb_result_t [ISSUE_WIDTH-1:0] wb;
    int unsigned                  chk_errors;
    int unsigned                  chk_writes;

    row_t        prog [NUM_ROWS];
    logic [31:0] lfsr;
    int unsigned cycles;
    int unsigned ready_low_cycles;
    int unsigned dest_rows;

    issue_top DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid_i (in_valid),
        .in_instr_i (in_instr),
        .in_ready_o (in_ready),
        .wb_o       (wb)
    );

    issue_checker chk (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_i        (wb),
        .error_cnt_o (chk_errors),
        .write_cnt_o (chk_writes)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic pick_gap(output int gap);
        lfsr = lfsr_step(lfsr);
        gap  = int'(lfsr[0]);
        lfsr = lfsr_step(lfsr);
        gap  = gap * 2 + int'(lfsr[0]);
    endtask

    function automatic row_t make_row(input op_e op, input int rd, input int rs1, input int rs2,
                                      input logic use_imm, input logic [IMM_W-1:0] imm,
                                      input logic [XLEN-1:0] expected);
        row_t r;
        r = '0;
        r.instr.op        = op;
        r.instr.rd        = REG_ADDR_W'(rd);
        r.instr.rs1       = REG_ADDR_W'(rs1);
        r.instr.rs2       = REG_ADDR_W'(rs2);
        r.instr.rd_valid  = 1'b1;
        r.instr.rs1_valid = 1'b1;
        r.instr.rs2_valid = !use_imm;
        r.instr.use_imm   = use_imm;
        r.instr.imm       = imm;
        r.expected        = expected;
        return r;
    endfunction

    // Expected values follow the ISA rules with every register starting at zero
    task automatic build_program();
        // Independent immediate loads
        prog[0]  = make_row(OP_ADD, 1, 0, 0, 1'b1, 16'h0005, 32'h0000_0005);
        prog[1]  = make_row(OP_ADD, 2, 0, 0, 1'b1, 16'h0003, 32'h0000_0003);
        prog[2]  = make_row(OP_OR,  3, 0, 0, 1'b1, 16'h00f0, 32'h0000_00f0);
        prog[3]  = make_row(OP_XOR, 4, 0, 0, 1'b1, 16'h0ff0, 32'h0000_0ff0);
        // Dependent chain through EX forwarding
        prog[4]  = make_row(OP_ADD, 6, 1, 2, 1'b0, 16'h0000, 32'h0000_0008);
        prog[5]  = make_row(OP_SUB, 6, 6, 2, 1'b0, 16'h0000, 32'h0000_0005);
        prog[6]  = make_row(OP_XOR, 7, 6, 4, 1'b0, 16'h0000, 32'h0000_0ff5);
        prog[7]  = make_row(OP_ADD, 8, 7, 6, 1'b0, 16'h0000, 32'h0000_0ffa);
        // Negative immediate, SUB and shifts
        prog[8]  = make_row(OP_ADD, 9, 0, 0, 1'b1, 16'hfffc, 32'hffff_fffc);
        prog[9]  = make_row(OP_SUB, 10, 1, 9, 1'b0, 16'h0000, 32'h0000_0009);
        prog[10] = make_row(OP_SLL, 11, 2, 0, 1'b1, 16'h0004, 32'h0000_0030);
        prog[11] = make_row(OP_SLL, 12, 1, 10, 1'b0, 16'h0000, 32'h0000_0a00);
        prog[12] = make_row(OP_SLL, 13, 2, 0, 1'b1, 16'h0023, 32'h0000_0018);
        // r0 written, then read back as zero
        prog[13] = make_row(OP_ADD, 0, 1, 2, 1'b0, 16'h0000, 32'h0000_0008);
        prog[14] = make_row(OP_ADD, 14, 0, 1, 1'b0, 16'h0000, 32'h0000_0005);
        prog[15] = make_row(OP_OR,  15, 0, 0, 1'b0, 16'h0000, 32'h0000_0000);
        prog[16] = make_row(OP_ADD, 1, 1, 0, 1'b1, 16'd100, 32'h0000_0000);
        prog[16].instr.rd_valid = 1'b0;
        prog[17] = make_row(OP_ADD, 5, 0, 0, 1'b1, 16'h0001, 32'h0000_0001);
        // MUL, dependent read and a WAW on r4
        prog[18] = make_row(OP_MUL, 4, 2, 10, 1'b0, 16'h0000, 32'h0000_001b);
        prog[19] = make_row(OP_ADD, 7, 4, 1, 1'b0, 16'h0000, 32'h0000_0020);
        prog[20] = make_row(OP_ADD, 4, 1, 0, 1'b1, 16'h0001, 32'h0000_0006);
        prog[21] = make_row(OP_SUB, 8, 4, 2, 1'b0, 16'h0000, 32'h0000_0003);
        // Burst where the MUL chain drains slower than the pushes arrive
        for (int k = 0; k < 10; k++) begin
            prog[22+k] = make_row(OP_MUL, 5, 5, 0, 1'b1, 16'h0002, 32'h1 << (k + 1));
        end
        prog[32] = make_row(OP_ADD, 9, 5, 2, 1'b0, 16'h0000, 32'h0000_0403);
        prog[33] = make_row(OP_XOR, 1, 5, 9, 1'b0, 16'h0000, 32'h0000_0003);
        prog[34] = make_row(OP_SLL, 12, 1, 0, 1'b1, 16'h0008, 32'h0000_0300);
        prog[35] = make_row(OP_ADD, 15, 12, 14, 1'b0, 16'h0000, 32'h0000_0305);
        for (int i = 22; i < NUM_ROWS; i++) begin
            prog[i].burst = 1'b1;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, writebacks still outstanding", cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int gap;
        int missing;
        int unsigned total;
        int unsigned props_fails;
        rst_n            = 1'b0;
        in_valid         = 1'b0;
        in_instr         = '0;
        lfsr             = 32'h8870_975d;
        ready_low_cycles = 0;
        dest_rows        = 0;
        total            = 0;
        build_program();
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (prog[i].instr.rd_valid) begin
                chk.add_expected(int'(prog[i].instr.rd), i, prog[i].expected);
                dest_rows++;
            end
        end

        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        for (int i = 0; i < NUM_ROWS; i++) begin
            in_valid = 1'b1;
            in_instr = prog[i].instr;
            while (!in_ready) begin
                ready_low_cycles++;
                @(negedge clk);
            end
            @(negedge clk);
            if (!prog[i].instr.rd_valid) $display("row %0d: accepted, no destination", i);
            if (prog[i].burst) gap = 0;
            else pick_gap(gap);
            if (gap > 0) begin
                in_valid = 1'b0;
                repeat (gap) @(negedge clk);
            end
        end
        in_valid = 1'b0;

        while (chk_writes < dest_rows) @(negedge clk);
        // Room for any stray late write to show up
        repeat (20) @(negedge clk);
        chk.report_missing(missing);
        total = chk_errors + missing;
        if (chk_writes != dest_rows) begin
            $display("Writeback count %0d differs from %0d rows with a destination",
                     chk_writes, dest_rows);
            total++;
        end
        if (ready_low_cycles == 0) begin
            $display("in_ready_o never went low during the burst");
            total++;
        end
        props_fails = DUT.u_dispatch.u_dispatch_props.fail_count;
        total = total + props_fails;
        $display("Rows %0d, writebacks %0d of %0d, ready low %0d cycles, errors %0d",
                 NUM_ROWS, chk_writes, dest_rows, ready_low_cycles, total);
        if (total == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
